/* build.f */
hw/imem_pkg.sv
hw/fetch_pkg.sv
hw/fetch_addr_gen.sv
hw/fetch_resp_filter.sv
hw/fetch_inst_queue.sv
hw/fetch_top.sv
dv/fetch_tb_props.sv
dv/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_stage

sources:
  - target: any(rtl, test)
    files:
      - hw/imem_pkg.sv
      - hw/fetch_pkg.sv
      - hw/fetch_addr_gen.sv
      - hw/fetch_resp_filter.sv
      - hw/fetch_inst_queue.sv
      - hw/fetch_top.sv
  - target: test
    files:
      - dv/fetch_tb_props.sv
      - dv/fetch_tb.sv

/* dv/fetch_tb.sv */
/*
 * Fetch stage testbench. Applies a table of loads and consume patterns
 * against a line memory model and checks the decode window and pointer.
 */
module fetch_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import imem_pkg::*;
   import fetch_pkg::*;

   typedef struct {
      string    name;
      addr_t    addr;
      seg_t     cs;
      consume_t bpr;
      int       handshakes;
      int       ready_every;
      bit       flush;
   } row_t;

   // Name, load address, cs, bytes per handshake, handshakes, ready 1 in N, flush first
   row_t rows [5] = '{
      '{"aligned_seq",     32'h0000_1000, 16'h0100, 4'd4,  24, 1, 1'b0},
      '{"unaligned_seq",   32'h0000_2037, 16'h0200, 4'd7,  20, 2, 1'b0},
      '{"max_consume",     32'h0001_00F9, 16'hFFFF, 4'd15, 12, 1, 1'b0},
      '{"flush_in_flight", 32'h0000_3A0C, 16'h0010, 4'd5,  16, 3, 1'b1},
      '{"single_byte",     32'h0000_4FFE, 16'h0000, 4'd1,  24, 2, 1'b1}
   };

   logic     clk_i;
   logic     rst_n_i;
   logic     flush_i;
   logic     load_i;
   addr_t    load_address_i;
   seg_t     cs_i;
   logic     imem_valid_o;
   logic     imem_ready_i;
   addr_t    imem_address_o;
   logic     imem_dp_valid_i;
   logic     imem_dp_ready_o;
   line_t    imem_dp_data_i;
   logic     f_valid_o;
   logic     f_ready_i;
   consume_t f_bytes_read_i;
   qcount_t  f_valid_bytes_o;
   window_t  f_instruction_o;
   addr_t    f_pc_o;

   int    seed = 59;
   int    mismatches = 0;
   int    failures = 0;
   string cur_name = "reset";
   bit    mem_pending = 1'b0;
   int    mem_delay;
   addr_t mem_addr;
   addr_t exp_req_addr;
   addr_t head;
   addr_t pc_exp;

   fetch_top i_fetch_top (.*);

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // Memory contents derived from the low address byte
   function automatic byte_t mem_byte(addr_t a);
      return a[7:0] ^ 8'h5A;
   endfunction

   task automatic check_byte(string what, byte_t exp, byte_t act);
      if (act !== exp) begin
         mismatches++;
         $display("MISMATCH %s %s: expected %02h, actual %02h", cur_name, what, exp, act);
      end
   endtask

   task automatic check_pc(string what, addr_t exp, addr_t act);
      if (act !== exp) begin
         mismatches++;
         $display("MISMATCH %s %s: expected %08h, actual %08h", cur_name, what, exp, act);
      end
   endtask

   // Upper bound on a byte count
   task automatic check_count(string what, qcount_t limit, qcount_t act);
      if (act > limit || $isunknown(act)) begin
         mismatches++;
         $display("MISMATCH %s %s: expected <= %0d, actual %0d", cur_name, what, limit, act);
      end
   endtask

   task automatic match_window();
      for (int i = 0; i < int'(f_valid_bytes_o); i++) begin
         check_byte($sformatf("window byte %0d", i), mem_byte(head + addr_t'(i)),
                    f_instruction_o[i*8 +: 8]);
      end
      check_pc("f_pc_o", pc_exp, f_pc_o);
   endtask

   // Line memory with random latency and random request stalls
   initial begin
      bit    req_fire;
      bit    rsp_fire;
      addr_t req_addr;
      imem_ready_i    = 1'b0;
      imem_dp_valid_i = 1'b0;
      imem_dp_data_i  = '0;
      forever begin
         @(negedge clk_i);
         req_fire = imem_valid_o && imem_ready_i;
         rsp_fire = imem_dp_valid_i && imem_dp_ready_o;
         req_addr = imem_address_o;
         // Requests taken in a redirect cycle are stale
         if (req_fire && rst_n_i && !load_i && !flush_i) begin
            check_pc("request address", exp_req_addr, req_addr);
            exp_req_addr = exp_req_addr + addr_t'(LINE_BYTES);
         end
         @(posedge clk_i);
         #2;
         if (rsp_fire) begin
            imem_dp_valid_i = 1'b0;
            mem_pending     = 1'b0;
         end
         if (req_fire) begin
            mem_pending = 1'b1;
            mem_addr    = req_addr;
            mem_delay   = $unsigned($random(seed)) % 6;
         end
         if (mem_pending && !imem_dp_valid_i) begin
            if (mem_delay == 0) begin
               imem_dp_valid_i = 1'b1;
               for (int i = 0; i < LINE_BYTES; i++) begin
                  imem_dp_data_i[i*8 +: 8] = mem_byte(mem_addr + addr_t'(i));
               end
            end else begin
               mem_delay--;
            end
         end
         imem_ready_i = ($unsigned($random(seed)) % 4) != 0;
      end
   end

   task automatic apply_load(addr_t addr, seg_t cs);
      @(posedge clk_i);
      #2;
      load_i         = 1'b1;
      load_address_i = addr;
      cs_i           = cs;
      exp_req_addr   = {addr[31:4], 4'h0};
      @(posedge clk_i);
      #2;
      load_i = 1'b0;
   endtask

   // Flush right after a request is accepted
   task automatic flush_in_flight();
      do @(negedge clk_i); while (!(imem_valid_o && imem_ready_i));
      @(posedge clk_i);
      #2;
      flush_i = 1'b1;
      @(posedge clk_i);
      #2;
      flush_i = 1'b0;
   endtask

   task automatic consume_once(consume_t bpr, int every);
      do @(negedge clk_i); while (f_valid_bytes_o < qcount_t'(bpr));
      match_window();
      for (int s = 1; s < every; s++) begin
         @(posedge clk_i);
      end
      @(posedge clk_i);
      #2;
      f_bytes_read_i = bpr;
      f_ready_i      = 1'b1;
      @(posedge clk_i);
      #2;
      f_ready_i = 1'b0;
      head      = head + addr_t'(bpr);
      pc_exp    = pc_exp + addr_t'(bpr);
   endtask

   // Decode stalled until memory traffic stops with a full window
   task automatic stall_until_full();
      int quiet;
      int cycles;
      quiet  = 0;
      cycles = 0;
      while (quiet < 8 && cycles < 120) begin
         @(negedge clk_i);
         match_window();
         check_count("f_valid_bytes_o", qcount_t'(WINDOW_BYTES), f_valid_bytes_o);
         if (!imem_valid_o && !mem_pending && f_valid_bytes_o == qcount_t'(WINDOW_BYTES)) begin
            quiet++;
         end else begin
            quiet = 0;
         end
         cycles++;
      end
      if (quiet < 8) begin
         failures++;
         $display("ERROR %s: memory requests did not stop with a full queue", cur_name);
      end else if (imem_dp_ready_o) begin
         failures++;
         $display("ERROR %s: imem_dp_ready_o high with no room for a line", cur_name);
      end
   endtask

   initial begin
      longint limit_ns;
      limit_ns = 10000;
      foreach (rows[r]) begin
         limit_ns += rows[r].handshakes * 200;
      end
      #(limit_ns);
      $display("Timeout: run still busy after %0d ns", limit_ns);
      $display("test failed");
      $finish;
   end

   initial begin
      rst_n_i        = 1'b0;
      flush_i        = 1'b0;
      load_i         = 1'b0;
      load_address_i = '0;
      cs_i           = '0;
      f_ready_i      = 1'b0;
      f_bytes_read_i = 4'd1;
      repeat (8) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      // Nothing moves before the first load
      repeat (10) begin
         @(negedge clk_i);
         if (imem_valid_o || f_valid_o || imem_dp_ready_o) begin
            failures++;
            $display("ERROR reset: request, response ready or window valid before any load");
         end
      end
      foreach (rows[r]) begin
         cur_name = rows[r].name;
         if (rows[r].flush) begin
            apply_load(rows[r].addr ^ 32'h80, rows[r].cs);
            flush_in_flight();
         end
         apply_load(rows[r].addr, rows[r].cs);
         head   = rows[r].addr;
         pc_exp = rows[r].addr - {16'h0000, rows[r].cs};
         for (int k = 0; k < rows[r].handshakes; k++) begin
            consume_once(rows[r].bpr, rows[r].ready_every);
         end
         stall_until_full();
      end
      failures += i_fetch_top.i_props.fail_count;
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* dv/fetch_tb_props.sv */
/*
 * Handshake and queue rules of the fetch stage as concurrent assertions.
 * Bound into fetch_top, failures are counted for the testbench.
 */
module fetch_tb_props (
   input logic               clk_i,
   input logic               rst_n_i,
   input logic               flush_i,
   input logic               load_i,
   input logic               imem_valid_i,
   input logic               imem_ready_i,
   input imem_pkg::addr_t    imem_address_i,
   input logic               imem_dp_valid_i,
   input logic               imem_dp_ready_i,
   input fetch_pkg::qcount_t f_valid_bytes_i
);
   timeunit 1ns;
   timeprecision 1ps;
   import fetch_pkg::*;

   int unsigned fail_count = 0;
   logic        req_fire;
   logic        rsp_fire;
   logic        in_flight_q;

   assign req_fire = imem_valid_i & imem_ready_i;
   assign rsp_fire = imem_dp_valid_i & imem_dp_ready_i;

   // Mirror of the single request in flight
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         in_flight_q <= 1'b0;
      end else if (req_fire) begin
         in_flight_q <= 1'b1;
      end else if (rsp_fire) begin
         in_flight_q <= 1'b0;
      end
   end

   // Stalled request holds unless a redirect moves it
   req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      imem_valid_i && !imem_ready_i && !flush_i && !load_i
      |=> imem_valid_i && $stable(imem_address_i))
   else begin
      fail_count++;
      $error("request dropped or moved while imem_ready_i low");
   end

   one_in_flight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      in_flight_q |-> !req_fire)
   else begin
      fail_count++;
      $error("second request accepted before the response");
   end

   window_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      f_valid_bytes_i <= qcount_t'(WINDOW_BYTES))
   else begin
      fail_count++;
      $error("f_valid_bytes_o above window size");
   end

   flush_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flush_i && !load_i |=> !imem_valid_i)
   else begin
      fail_count++;
      $error("request strobe high after a flush");
   end

endmodule

bind fetch_top fetch_tb_props i_props (
   .clk_i           (clk_i),
   .rst_n_i         (rst_n_i),
   .flush_i         (flush_i),
   .load_i          (load_i),
   .imem_valid_i    (imem_valid_o),
   .imem_ready_i    (imem_ready_i),
   .imem_address_i  (imem_address_o),
   .imem_dp_valid_i (imem_dp_valid_i),
   .imem_dp_ready_i (imem_dp_ready_o),
   .f_valid_bytes_i (f_valid_bytes_o)
);

/* hw/fetch_top.sv */
/*
 * Fetch stage top level. Wires the address generator, the response filter
 * and the instruction queue between instruction memory and decode.
 */
module fetch_top (
   input  logic                clk_i,
   input  logic                rst_n_i,

   // Control
   input  logic                flush_i,
   input  logic                load_i,
   input  imem_pkg::addr_t     load_address_i,
   input  fetch_pkg::seg_t     cs_i,

   // Instruction memory request
   output logic                imem_valid_o,
   input  logic                imem_ready_i,
   output imem_pkg::addr_t     imem_address_o,

   // Instruction memory response
   input  logic                imem_dp_valid_i,
   output logic                imem_dp_ready_o,
   input  imem_pkg::line_t     imem_dp_data_i,

   // Decode
   output logic                f_valid_o,
   input  logic                f_ready_i,
   input  fetch_pkg::consume_t f_bytes_read_i,
   output fetch_pkg::qcount_t  f_valid_bytes_o,
   output fetch_pkg::window_t  f_instruction_o,
   output imem_pkg::addr_t     f_pc_o
);

   logic outstanding;
   logic resp_valid;
   logic line_room;

   fetch_addr_gen i_addr_gen (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .flush_i        (flush_i),
      .load_i         (load_i),
      .load_address_i (load_address_i),
      .outstanding_i  (outstanding),
      .line_room_i    (line_room),
      .imem_ready_i   (imem_ready_i),
      .imem_valid_o   (imem_valid_o),
      .imem_address_o (imem_address_o)
   );

   fetch_resp_filter i_resp_filter (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .flush_i         (flush_i),
      .load_i          (load_i),
      .imem_valid_i    (imem_valid_o),
      .imem_ready_i    (imem_ready_i),
      .imem_dp_valid_i (imem_dp_valid_i),
      .line_room_i     (line_room),
      .outstanding_o   (outstanding),
      .imem_dp_ready_o (imem_dp_ready_o),
      .resp_valid_o    (resp_valid)
   );

   fetch_inst_queue i_inst_queue (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .flush_i         (flush_i),
      .load_i          (load_i),
      .load_address_i  (load_address_i),
      .cs_i            (cs_i),
      .resp_valid_i    (resp_valid),
      .imem_dp_ready_i (imem_dp_ready_o),
      .imem_dp_data_i  (imem_dp_data_i),
      .f_ready_i       (f_ready_i),
      .f_bytes_read_i  (f_bytes_read_i),
      .line_room_o     (line_room),
      .f_valid_o       (f_valid_o),
      .f_valid_bytes_o (f_valid_bytes_o),
      .f_instruction_o (f_instruction_o),
      .f_pc_o          (f_pc_o)
   );

endmodule

/* hw/fetch_inst_queue.sv */
/*
 * Instruction byte queue. Appends memory lines, shifts out the bytes that
 * decode consumed, offers a 32-byte window and keeps the head pointer.
 */
module fetch_inst_queue (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               flush_i,
   input  logic               load_i,
   input  imem_pkg::addr_t    load_address_i,
   input  fetch_pkg::seg_t    cs_i,
   input  logic               resp_valid_i,
   input  logic               imem_dp_ready_i,
   input  imem_pkg::line_t    imem_dp_data_i,
   input  logic               f_ready_i,
   input  fetch_pkg::consume_t f_bytes_read_i,
   output logic               line_room_o,
   output logic               f_valid_o,
   output fetch_pkg::qcount_t f_valid_bytes_o,
   output fetch_pkg::window_t f_instruction_o,
   output imem_pkg::addr_t    f_pc_o
);
   import imem_pkg::*;
   import fetch_pkg::*;

   byte_t     q_r [QUEUE_BYTES];
   byte_t     q_d [QUEUE_BYTES];
   qcount_t   count_q;
   qcount_t   count_d;
   line_off_t skip_q;
   addr_t     pc_q;
   logic      redirect;
   logic      push;
   logic      pop;
   qcount_t   pop_n;
   qcount_t   push_n;
   qcount_t   base;

   assign redirect = flush_i | load_i;
   assign push     = resp_valid_i & imem_dp_ready_i;
   assign pop      = f_valid_o & f_ready_i;

   // Bytes leaving at the head and arriving at the tail this cycle
   assign pop_n  = pop ? qcount_t'(f_bytes_read_i) : '0;
   assign push_n = push ? qcount_t'(LINE_BYTES) - qcount_t'(skip_q) : '0;

   // Fill level after the pop, where the new line starts
   assign base    = count_q - pop_n;
   assign count_d = redirect ? '0 : base + push_n;

   always_comb begin
      int src;
      int lidx;
      for (int i = 0; i < QUEUE_BYTES; i++) begin
         src    = i + int'(pop_n);
         lidx   = i - int'(base) + int'(skip_q);
         q_d[i] = q_r[i];
         if (src < QUEUE_BYTES) begin
            q_d[i] = q_r[src];
         end
         // Tail slots take the line, first skip bytes left out
         if (push && (i >= int'(base)) && (lidx < LINE_BYTES)) begin
            q_d[i] = imem_dp_data_i[lidx*8 +: 8];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
         skip_q  <= '0;
      end else begin
         count_q <= count_d;
         if (load_i) begin
            skip_q <= line_off_t'(load_address_i);
         end else if (flush_i || push) begin
            // One-shot, only the first line after a load is unaligned
            skip_q <= '0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      q_r <= q_d;
   end

   // Head pointer, segment relative
   always_ff @(posedge clk_i) begin
      if (load_i) begin
         pc_q <= load_address_i - addr_t'(cs_i);
      end else if (pop && !flush_i) begin
         pc_q <= pc_q + addr_t'(f_bytes_read_i);
      end
   end

   assign f_valid_o   = (count_q != '0);
   assign line_room_o = (count_q <= qcount_t'(QUEUE_BYTES - LINE_BYTES));
   assign f_pc_o      = pc_q;

   assign f_valid_bytes_o = (count_q > qcount_t'(WINDOW_BYTES)) ?
                            qcount_t'(WINDOW_BYTES) : count_q;

   // Window is the first 32 slots, slots past the count are stale
   always_comb begin
      for (int i = 0; i < WINDOW_BYTES; i++) begin
         f_instruction_o[i*8 +: 8] = q_r[i];
      end
   end

endmodule

/* hw/fetch_resp_filter.sv */
/*
 * Memory response filter. Tracks the request in flight, marks it stale
 * on a flush or load, and hides the stale line from the queue.
 */
module fetch_resp_filter (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic flush_i,
   input  logic load_i,
   input  logic imem_valid_i,
   input  logic imem_ready_i,
   input  logic imem_dp_valid_i,
   input  logic line_room_i,
   output logic outstanding_o,
   output logic imem_dp_ready_o,
   output logic resp_valid_o
);

   logic outstanding_q;
   logic drop_q;
   logic redirect;
   logic req_accept;
   logic resp_accept;

   assign redirect    = flush_i | load_i;
   assign req_accept  = imem_valid_i & imem_ready_i;

   // Stale lines are always taken, fresh ones need queue room
   assign imem_dp_ready_o = outstanding_q & (drop_q | line_room_i);
   assign resp_accept     = imem_dp_valid_i & imem_dp_ready_o;
   assign resp_valid_o    = imem_dp_valid_i & ~drop_q;
   assign outstanding_o   = outstanding_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         outstanding_q <= 1'b0;
         drop_q        <= 1'b0;
      end else begin
         if (req_accept) begin
            outstanding_q <= 1'b1;
         end else if (resp_accept) begin
            outstanding_q <= 1'b0;
         end

         // Request accepted in the redirect cycle is stale as well
         if (resp_accept) begin
            drop_q <= 1'b0;
         end else if (redirect && (outstanding_q || req_accept)) begin
            drop_q <= 1'b1;
         end
      end
   end

endmodule

/* hw/fetch_addr_gen.sv */
/*
 * Fetch address generator. Keeps the next aligned line address and raises
 * the memory request strobe, at most one request in flight.
 */
module fetch_addr_gen (
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  logic            flush_i,
   input  logic            load_i,
   input  imem_pkg::addr_t load_address_i,
   input  logic            outstanding_i,
   input  logic            line_room_i,
   input  logic            imem_ready_i,
   output logic            imem_valid_o,
   output imem_pkg::addr_t imem_address_o
);
   import imem_pkg::*;
   import fetch_pkg::*;

   ag_state_e state_q;
   ag_state_e state_d;
   addr_t     line_addr_q;
   addr_t     line_addr_d;
   logic      req_accept;

   // A stale request still in flight holds the new one back
   assign imem_valid_o   = (state_q == REQUEST) && !outstanding_i;
   assign imem_address_o = line_addr_q;
   assign req_accept     = imem_valid_o && imem_ready_i;

   always_comb begin
      state_d     = state_q;
      line_addr_d = line_addr_q;
      if (load_i) begin
         // Load beats a flush in the same cycle
         state_d     = REQUEST;
         line_addr_d = load_address_i & ~addr_t'(LINE_BYTES - 1);
      end else if (flush_i) begin
         state_d = IDLE;
      end else begin
         case (state_q)
            IDLE: begin
               state_d = IDLE;
            end
            REQUEST: begin
               if (req_accept) begin
                  state_d     = WAIT;
                  line_addr_d = line_addr_q + addr_t'(LINE_BYTES);
               end
            end
            WAIT: begin
               // Next line only once the last one landed and fits
               if (!outstanding_i && line_room_i) begin
                  state_d = REQUEST;
               end
            end
            default: begin
               state_d = IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      line_addr_q <= line_addr_d;
   end

endmodule

/* hw/fetch_pkg.sv */
/*
 * Decode side definitions for the fetch stage: window and queue sizes,
 * byte counts, code segment and the address generator states.
 */
package fetch_pkg;

   // Bytes offered to decode in one window
   localparam int unsigned WINDOW_BYTES = 32;

   // Queue capacity, three memory lines
   localparam int unsigned QUEUE_BYTES = 48;

   // Single instruction byte
   typedef logic [7:0] byte_t;

   // Decode window, byte 0 in the low bits
   typedef logic [WINDOW_BYTES*8-1:0] window_t;

   // Byte count in the queue, 0 to 48
   typedef logic [5:0] qcount_t;

   // Bytes taken by decode per handshake, 1 to 15
   typedef logic [3:0] consume_t;

   // Code segment base
   typedef logic [15:0] seg_t;

   // Address generator FSM
   typedef enum logic [1:0] {
      IDLE,
      REQUEST,
      WAIT
   } ag_state_e;

endpackage

/* hw/imem_pkg.sv */
/*
 * Instruction memory side definitions for the fetch stage: line size,
 * linear address and byte offset within a line.
 */
package imem_pkg;

   // Bytes per memory line
   localparam int unsigned LINE_BYTES = 16;

   // Linear fetch address
   typedef logic [31:0] addr_t;

   // One memory line, byte 0 sits in bits 7:0
   typedef logic [LINE_BYTES*8-1:0] line_t;

   // Byte position inside a line
   typedef logic [$clog2(LINE_BYTES)-1:0] line_off_t;

endpackage
